/* hw/cpu_decode.sv */
`timescale 1ns/10ps

module cpu_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::instr_t  if_instr,
    input  logic             rw_stall,
    input  cpu_pkg::mem_wb_t wb,
    output cpu_pkg::id_ex_t  id_ex
);
    import cpu_pkg::*;

    ctrl_t    ctrl;
    reg_idx_t rt_sel;
    word_t    rs_data;
    word_t    rt_data;
    word_t    imm_sext;

    assign rt_sel   = src_b_sel(if_instr);
    assign imm_sext = {{16{if_instr.i_form.imm[15]}}, if_instr.i_form.imm};

    cpu_regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_sel  (if_instr.i_form.rs),
        .rt_sel  (rt_sel),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    //////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////
    always_comb begin
        ctrl = '0;
        case (if_instr.r_form.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                ctrl.alu_op      = if_instr.r_form.opcode;
                ctrl.rf_write_en = 1'b1;
            end
            OP_ADDI: begin
                ctrl.alu_op      = OP_ADDI;
                ctrl.imm_src     = 1'b1;
                ctrl.rf_write_en = 1'b1;
            end
            OP_LD: begin
                ctrl.alu_op      = OP_LD;
                ctrl.imm_src     = 1'b1;
                ctrl.rf_write_en = 1'b1;
                ctrl.mem_read_en = 1'b1;
                ctrl.wb_mem_src  = 1'b1;
            end
            OP_ST: begin
                ctrl.alu_op       = OP_ST;
                ctrl.imm_src      = 1'b1;
                ctrl.mem_write_en = 1'b1;
            end
            OP_BEQ, OP_BNEQ, OP_BLTZ, OP_BGTZ, OP_JMP:
                ctrl.alu_op = if_instr.r_form.opcode;
            default: ;   // unknown codes stay nop
        endcase
        ctrl.is_branch = is_branch_op(if_instr.r_form.opcode);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (rw_stall) begin
            id_ex <= '0;   // bubble
        end else begin
            id_ex.ctrl    <= ctrl;
            id_ex.op_a    <= rs_data;
            id_ex.op_b    <= ctrl.imm_src ? imm_sext : rt_data;
            id_ex.st_data <= rt_data;
            id_ex.imm     <= imm_sext;
            id_ex.wb_reg  <= if_instr.r_form.rd;
        end
    end

endmodule

/* hw/cpu_execute.sv */
`timescale 1ns/10ps

module cpu_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::id_ex_t    id_ex,
    output cpu_pkg::ex_mem_t   ex_mem,
    output cpu_pkg::redirect_t redirect
);
    import cpu_pkg::*;

    word_t alu_y;
    logic  z_flag;
    logic  n_flag;
    logic  flag_en;
    logic  taken;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        case (id_ex.ctrl.alu_op)
            OP_ADD, OP_ADDI, OP_LD, OP_ST: alu_y = id_ex.op_a + id_ex.op_b;
            OP_SUB:  alu_y = id_ex.op_a - id_ex.op_b;
            OP_AND:  alu_y = id_ex.op_a & id_ex.op_b;
            OP_OR:   alu_y = id_ex.op_a | id_ex.op_b;
            default: alu_y = '0;
        endcase
    end

    // loads leave the flags alone
    assign flag_en = id_ex.ctrl.rf_write_en & ~id_ex.ctrl.mem_read_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            z_flag <= 1'b0;
            n_flag <= 1'b0;
        end else if (flag_en) begin
            z_flag <= (alu_y == '0);
            n_flag <= alu_y[31];
        end
    end

    always_comb begin
        taken = 1'b0;
        if (id_ex.ctrl.is_branch) begin
            case (id_ex.ctrl.alu_op)
                OP_BEQ:  taken = z_flag;
                OP_BNEQ: taken = ~z_flag;
                OP_BLTZ: taken = n_flag & ~z_flag;
                OP_BGTZ: taken = ~n_flag & ~z_flag;
                OP_JMP:  taken = 1'b1;
                default: taken = 1'b0;
            endcase
        end
    end

    assign redirect.valid  = taken;
    assign redirect.target = id_ex.imm[15:0];   // imm is a byte address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_y;
            ex_mem.st_data    <= id_ex.st_data;
            ex_mem.wb_reg     <= id_ex.wb_reg;
        end
    end

endmodule

/* hw/cpu_fetch.sv */
`timescale 1ns/10ps

module cpu_fetch #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_valid,
    input  cpu_pkg::host_load_t load,
    input  logic                start,
    input  logic                rw_stall,
    input  logic                jb_stall,
    input  cpu_pkg::redirect_t  redirect,
    output cpu_pkg::instr_t     if_instr,
    output logic                running
);
    import cpu_pkg::*;

    localparam int IA_W = $clog2(IMEM_DEPTH);

    instr_t          imem [IMEM_DEPTH];
    pc_t             pc;
    pc_t             pc_next;
    logic            go;
    logic            take_br;
    logic [IA_W-1:0] rd_idx;

    assign go      = running | start;
    assign take_br = running & redirect.valid;

    // memory is addressed with next pc so IF/ID lines up with pc
    always_comb begin
        if (!running)
            pc_next = start ? '0 : pc;
        else if (take_br)
            pc_next = redirect.target;
        else if (rw_stall || jb_stall)
            pc_next = pc;                  // hold
        else
            pc_next = pc + 16'd4;
    end

    assign rd_idx = pc_next[IA_W+1:2];

    always_ff @(posedge clk) begin
        if (load_valid)
            imem[IA_W'(load.idx)] <= load.data;   // host load port
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            pc       <= '0;
            if_instr <= NOP_INSTR;
        end else begin
            if (start)
                running <= 1'b1;
            pc <= pc_next;
            if (!go)
                if_instr <= NOP_INSTR;
            else if (take_br)
                if_instr <= imem[rd_idx];   // branch target
            else if (jb_stall)
                if_instr <= NOP_INSTR;      // nop until branch resolves
            else if (!rw_stall)
                if_instr <= imem[rd_idx];
        end
    end

endmodule

/* hw/cpu_hazard.sv */
`timescale 1ns/10ps

module cpu_hazard (
    input  cpu_pkg::instr_t  if_instr,
    input  cpu_pkg::id_ex_t  id_ex,
    input  cpu_pkg::ex_mem_t ex_mem,
    input  cpu_pkg::mem_wb_t mem_wb,
    output logic             rw_stall,
    output logic             jb_stall
);
    import cpu_pkg::*;

    logic use_rs;
    logic use_rt;

    // a later stage still owes a write to r
    function automatic logic pending(reg_idx_t r);
        return (r != '0) &&
               ((id_ex.ctrl.rf_write_en  && id_ex.wb_reg  == r) ||
                (ex_mem.ctrl.rf_write_en && ex_mem.wb_reg == r) ||
                (mem_wb.rf_write_en      && mem_wb.wb_reg == r));
    endfunction

    always_comb begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (if_instr.r_form.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ST: begin
                use_rs = 1'b1;
                use_rt = 1'b1;   // rt, or rd for stores
            end
            OP_ADDI, OP_LD: use_rs = 1'b1;
            default: ;
        endcase
        rw_stall = (use_rs && pending(if_instr.r_form.rs)) ||
                   (use_rt && pending(src_b_sel(if_instr)));
    end

    assign jb_stall = is_branch_op(if_instr.r_form.opcode) | id_ex.ctrl.is_branch;

endmodule

/* hw/cpu_memory.sv */
`timescale 1ns/10ps

module cpu_memory #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::ex_mem_t  ex_mem,
    output cpu_pkg::mem_wb_t  mem_wb,
    output logic              host_wr_valid,
    output cpu_pkg::host_wr_t host_wr
);
    import cpu_pkg::*;

    localparam int DA_W = $clog2(DMEM_DEPTH);

    word_t           dmem [DMEM_DEPTH];
    logic [DA_W-1:0] idx;
    logic            to_host;
    logic            trap;
    word_t           ld_data;
    word_t           alu_q;
    logic            mem_src_q;
    logic            we_q;
    reg_idx_t        wb_reg_q;

    assign idx     = ex_mem.alu_result[DA_W+1:2];   // word address
    assign to_host = ex_mem.alu_result >= HOST_BASE;
    assign trap    = ex_mem.ctrl.mem_write_en & to_host;

    always_ff @(posedge clk) begin
        if (ex_mem.ctrl.mem_write_en && !to_host)
            dmem[idx] <= ex_mem.st_data;
        if (ex_mem.ctrl.mem_read_en)
            ld_data <= dmem[idx];                // synchronous read
        if (trap) begin
            host_wr.addr <= ex_mem.alu_result[15:0];
            host_wr.data <= ex_mem.st_data;
        end
        alu_q <= ex_mem.alu_result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_wr_valid <= 1'b0;
            we_q          <= 1'b0;
            mem_src_q     <= 1'b0;
            wb_reg_q      <= '0;
        end else begin
            host_wr_valid <= trap;   // single cycle strobe
            we_q          <= ex_mem.ctrl.rf_write_en;
            mem_src_q     <= ex_mem.ctrl.wb_mem_src;
            wb_reg_q      <= ex_mem.wb_reg;
        end
    end

    assign mem_wb.rf_write_en = we_q;
    assign mem_wb.wb_reg      = wb_reg_q;
    assign mem_wb.wb_data     = mem_src_q ? ld_data : alu_q;

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

    //////////////////////////////////////////////////
    // opcodes and basic types
    //////////////////////////////////////////////////

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h01,
        OP_SUB  = 8'h02,
        OP_AND  = 8'h03,
        OP_OR   = 8'h04,
        OP_ADDI = 8'h11,
        OP_LD   = 8'h81,
        OP_ST   = 8'h87,
        OP_BEQ  = 8'h31,
        OP_BNEQ = 8'h33,
        OP_BLTZ = 8'h35,
        OP_BGTZ = 8'h37,
        OP_JMP  = 8'h3D
    } opcode_t;

    typedef logic [3:0]  reg_idx_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] pc_t;   // byte address

    // one instruction word, two decodes
    typedef union packed {
        struct packed {
            opcode_t     opcode;
            reg_idx_t    rd;
            reg_idx_t    rs;
            reg_idx_t    rt;
            logic [11:0] unused;
        } r_form;
        struct packed {
            opcode_t     opcode;
            reg_idx_t    rd;
            reg_idx_t    rs;
            logic [15:0] imm;
        } i_form;
    } instr_t;

    localparam instr_t NOP_INSTR = '0;
    localparam word_t  HOST_BASE = 32'h0000_9000;   // stores at or above go to the host

    //////////////////////////////////////////////////
    // pipeline records
    //////////////////////////////////////////////////

    typedef struct packed {
        opcode_t alu_op;
        logic    imm_src;        // operand b from imm
        logic    rf_write_en;
        logic    mem_write_en;
        logic    mem_read_en;
        logic    wb_mem_src;     // writeback from load data
        logic    is_branch;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    op_a;
        word_t    op_b;
        word_t    st_data;
        word_t    imm;           // sign extended
        reg_idx_t wb_reg;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    st_data;
        reg_idx_t wb_reg;
    } ex_mem_t;

    typedef struct packed {
        logic     rf_write_en;
        reg_idx_t wb_reg;
        word_t    wb_data;
    } mem_wb_t;

    typedef struct packed {
        logic [7:0] idx;         // instruction word index
        word_t      data;
    } host_load_t;

    typedef struct packed {
        logic [15:0] addr;
        word_t       data;
    } host_wr_t;

    typedef struct packed {
        logic valid;
        pc_t  target;
    } redirect_t;

    // any 0x3x code is branch class
    function automatic logic is_branch_op(logic [7:0] op);
        return op[7:4] == 4'h3;
    endfunction

    // stores take their data from rd
    function automatic reg_idx_t src_b_sel(instr_t instr);
        return (instr.r_form.opcode == OP_ST) ? instr.r_form.rd : instr.r_form.rt;
    endfunction

endpackage

/* hw/cpu_regfile.sv */
`timescale 1ns/10ps

module cpu_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rs_sel,
    input  cpu_pkg::reg_idx_t rt_sel,
    output cpu_pkg::word_t    rs_data,
    output cpu_pkg::word_t    rt_data,
    input  cpu_pkg::mem_wb_t  wb
);
    import cpu_pkg::*;

    word_t regs [16];

    // r0 is cleared by reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            regs <= '{default: '0};
        else if (wb.rf_write_en && wb.wb_reg != '0)
            regs[wb.wb_reg] <= wb.wb_data;
    end

    assign rs_data = regs[rs_sel];   // combinational read
    assign rt_data = regs[rt_sel];

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_valid,
    input  cpu_pkg::host_load_t load,
    input  logic                start,
    output logic                host_wr_valid,
    output cpu_pkg::host_wr_t   host_wr,
    output logic                running
);
    import cpu_pkg::*;

    instr_t    if_instr;   // IF/ID
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    redirect_t redirect;
    logic      rw_stall;
    logic      jb_stall;

    cpu_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load       (load),
        .start      (start),
        .rw_stall   (rw_stall),
        .jb_stall   (jb_stall),
        .redirect   (redirect),
        .if_instr   (if_instr),
        .running    (running)
    );

    cpu_decode decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_instr (if_instr),
        .rw_stall (rw_stall),
        .wb       (mem_wb),
        .id_ex    (id_ex)
    );

    cpu_hazard hazard_i (
        .if_instr (if_instr),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .rw_stall (rw_stall),
        .jb_stall (jb_stall)
    );

    cpu_execute execute_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    cpu_memory #(.DMEM_DEPTH(DMEM_DEPTH)) memory_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_mem        (ex_mem),
        .mem_wb        (mem_wb),
        .host_wr_valid (host_wr_valid),
        .host_wr       (host_wr)
    );

endmodule

/* list.f */
+incdir+include
hw/cpu_pkg.sv
hw/cpu_regfile.sv
hw/cpu_fetch.sv
hw/cpu_decode.sv
hw/cpu_hazard.sv
hw/cpu_execute.sv
hw/cpu_memory.sv
hw/cpu_top.sv
test/tb_clock.sv
test/cpu_tb.sv

/* include/cpu_tb_programs.svh */
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

//////////////////////////////////////////////////
// test table with one program and its host writes per row
//////////////////////////////////////////////////

localparam int N_TESTS   = 4;
localparam int MAX_INSTR = 96;
localparam int MAX_WR    = 24;

string       test_name [N_TESTS];
instr_t      prog      [N_TESTS][MAX_INSTR];
int          prog_len  [N_TESTS];
host_wr_t    exp_wr    [N_TESTS][MAX_WR];
int          exp_len   [N_TESTS];
logic [15:0] next_host;   // address of the next host store

function automatic word_t sext(logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

function automatic instr_t i_instr(opcode_t op, reg_idx_t rd, reg_idx_t rs,
                                   logic [15:0] imm);
    instr_t w;
    w.i_form = '{op, rd, rs, imm};
    return w;
endfunction

function automatic instr_t r_instr(opcode_t op, reg_idx_t rd, reg_idx_t rs,
                                   reg_idx_t rt);
    instr_t w;
    w.r_form = '{op, rd, rs, rt, 12'h000};
    return w;
endfunction

task automatic emit(int t, instr_t w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
endtask

task automatic expect_write(int t, logic [15:0] addr, word_t value);
    exp_wr[t][exp_len[t]] = '{addr, value};
    exp_len[t]++;
endtask

// store rd at the next host address and expect it only if the path runs
task automatic host_store(int t, reg_idx_t rd, word_t value, logic runs);
    emit(t, i_instr(OP_ST, rd, 4'd0, next_host));
    if (runs)
        expect_write(t, next_host, value);
    next_host += 16'd4;
endtask

task automatic halt(int t);
    emit(t, i_instr(OP_JMP, 4'd0, 4'd0, 16'(prog_len[t] * 4)));   // jump to itself
endtask

// flags from a minus b decide whether the branch skips the fall-through marker
task automatic branch_case(int t, opcode_t op, logic [15:0] a, logic [15:0] b, int id);
    word_t diff;
    logic  z;
    logic  n;
    logic  taken;
    diff = sext(a) - sext(b);
    z    = (diff == 32'd0);
    n    = diff[31];
    case (op)
        OP_BEQ:  taken = z;
        OP_BNEQ: taken = !z;
        OP_BLTZ: taken = n && !z;
        OP_BGTZ: taken = !n && !z;
        default: taken = 1'b1;   // jmp
    endcase
    emit(t, i_instr(OP_ADDI, 4'd1, 4'd0, a));
    emit(t, i_instr(OP_ADDI, 4'd2, 4'd0, b));
    emit(t, r_instr(OP_SUB, 4'd3, 4'd1, 4'd2));
    emit(t, i_instr(op, 4'd0, 4'd0, 16'((prog_len[t] + 3) * 4)));
    emit(t, i_instr(OP_ADDI, 4'd9, 4'd0, 16'h0100 + 16'(2 * id)));   // fall-through
    host_store(t, 4'd9, 32'h0100 + 32'(2 * id), !taken);
    emit(t, i_instr(OP_ADDI, 4'd9, 4'd0, 16'h0101 + 16'(2 * id)));   // landing
    host_store(t, 4'd9, 32'h0101 + 32'(2 * id), 1'b1);
endtask

task automatic build_programs();
    logic [15:0] imm [4];
    word_t       v [8];
    for (int t = 0; t < N_TESTS; t++) begin
        prog_len[t] = 0;
        exp_len[t]  = 0;
    end
    foreach (imm[i])
        imm[i] = 16'($urandom);

    // dependent ALU chain where the next op reads each result
    test_name[0] = "alu_chain";
    next_host    = 16'h9000;
    v[0] = '0;
    v[1] = sext(imm[0]);
    v[2] = v[1] + sext(imm[1]);
    v[3] = v[2] + v[1];
    v[4] = v[2] - v[3];
    v[5] = v[4] & v[3];
    v[6] = v[5] | v[2];
    v[7] = v[6] + sext(imm[2]);
    emit(0, i_instr(OP_ADDI, 4'd1, 4'd0, imm[0]));
    emit(0, i_instr(OP_ADDI, 4'd2, 4'd1, imm[1]));
    emit(0, r_instr(OP_ADD,  4'd3, 4'd2, 4'd1));
    emit(0, r_instr(OP_SUB,  4'd4, 4'd2, 4'd3));
    emit(0, r_instr(OP_AND,  4'd5, 4'd4, 4'd3));
    emit(0, r_instr(OP_OR,   4'd6, 4'd5, 4'd2));
    emit(0, i_instr(OP_ADDI, 4'd7, 4'd6, imm[2]));
    for (int r = 1; r < 8; r++)
        host_store(0, reg_idx_t'(r), v[r], 1'b1);
    halt(0);

    // data memory round trip and an r0 that stays zero
    test_name[1] = "dmem_ld_st";
    next_host    = 16'h9000;
    emit(1, i_instr(OP_ADDI, 4'd1, 4'd0, imm[0]));
    emit(1, i_instr(OP_ADDI, 4'd2, 4'd0, imm[3]));
    emit(1, i_instr(OP_ADDI, 4'd5, 4'd0, 16'h0040));
    emit(1, i_instr(OP_ST,   4'd1, 4'd0, 16'h0010));
    emit(1, i_instr(OP_ST,   4'd2, 4'd0, 16'h0014));
    emit(1, i_instr(OP_ST,   4'd1, 4'd5, 16'h0004));   // base register address
    emit(1, i_instr(OP_LD,   4'd3, 4'd0, 16'h0010));
    emit(1, i_instr(OP_LD,   4'd4, 4'd0, 16'h0014));
    emit(1, i_instr(OP_LD,   4'd6, 4'd5, 16'h0004));
    host_store(1, 4'd3, sext(imm[0]), 1'b1);
    host_store(1, 4'd4, sext(imm[3]), 1'b1);
    host_store(1, 4'd6, sext(imm[0]), 1'b1);
    emit(1, i_instr(OP_ADDI, 4'd0, 4'd0, 16'h1234));
    repeat (4)
        emit(1, i_instr(OP_NOP, 4'd0, 4'd0, 16'h0000));   // let the r0 write retire
    host_store(1, 4'd0, 32'd0, 1'b1);
    halt(1);

    // every branch taken and not taken
    test_name[2] = "branches";
    next_host    = 16'h9000;
    branch_case(2, OP_BEQ,  16'd5, 16'd5, 0);
    branch_case(2, OP_BEQ,  16'd5, 16'd3, 1);
    branch_case(2, OP_BNEQ, 16'd5, 16'd3, 2);
    branch_case(2, OP_BNEQ, 16'd4, 16'd4, 3);
    branch_case(2, OP_BLTZ, 16'd3, 16'd5, 4);
    branch_case(2, OP_BLTZ, 16'd5, 16'd3, 5);
    branch_case(2, OP_BLTZ, 16'd4, 16'd4, 6);
    branch_case(2, OP_BGTZ, 16'd7, 16'd2, 7);
    branch_case(2, OP_BGTZ, 16'd2, 16'd7, 8);
    branch_case(2, OP_BGTZ, 16'd6, 16'd6, 9);
    branch_case(2, OP_JMP,  16'd1, 16'd1, 10);
    halt(2);

    // back-to-back host stores and the HOST_BASE edge
    test_name[3] = "host_burst";
    next_host    = 16'h9000;
    for (int r = 1; r < 5; r++)
        emit(3, i_instr(OP_ADDI, reg_idx_t'(r), 4'd0, imm[r - 1]));
    emit(3, i_instr(OP_ADDI, 4'd5, 4'd0, 16'h7000));
    for (int r = 1; r < 5; r++)
        host_store(3, reg_idx_t'(r), sext(imm[r - 1]), 1'b1);
    emit(3, i_instr(OP_ST, 4'd1, 4'd5, 16'h1FFC));   // 0x8ffc stays in data memory
    emit(3, i_instr(OP_ST, 4'd2, 4'd5, 16'h2000));
    expect_write(3, 16'h9000, sext(imm[1]));
    emit(3, i_instr(OP_ST, 4'd3, 4'd5, 16'h6FFC));
    expect_write(3, 16'hDFFC, sext(imm[2]));
    emit(3, i_instr(OP_ST, 4'd4, 4'd0, 16'hFFFC));
    expect_write(3, 16'hFFFC, sext(imm[3]));
    halt(3);
endtask

`endif

/* test/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int WAIT_LIMIT  = 2000;   // cycles per expected host write
    localparam int START_LIMIT = 20;
    localparam int QUIET_TIME  = 40;     // cycles watched after the last write

    logic       clk;
    logic       rst_n;
    logic       load_valid;
    host_load_t load;
    logic       start;
    logic       host_wr_valid;
    host_wr_t   host_wr;
    logic       running;

    int errors;         // current test
    int total_errors;
    int passed;
    int failed;

    `include "cpu_tb_programs.svh"

    tb_clock clock_i (.clk(clk));

    cpu_top #(.IMEM_DEPTH(256), .DMEM_DEPTH(256)) cpu_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_valid    (load_valid),
        .load          (load),
        .start         (start),
        .host_wr_valid (host_wr_valid),
        .host_wr       (host_wr),
        .running       (running)
    );

    //////////////////////////////////////////////////
    // checks and sequencing
    //////////////////////////////////////////////////

    // core must be quiet before start
    task automatic check_idle(int t, string phase);
        if (running !== 1'b0) begin
            $display("ERR %0s %0s: running = %h, expected 0", test_name[t], phase, running);
            errors++;
        end
        if (host_wr_valid !== 1'b0) begin
            $display("ERR %0s %0s: host_wr_valid = %h, expected 0",
                     test_name[t], phase, host_wr_valid);
            errors++;
        end
    endtask

    task automatic apply_reset(int t);
        rst_n      = 1'b0;
        load_valid = 1'b0;
        start      = 1'b0;
        repeat (10) begin
            @(posedge clk);
            @(negedge clk);
            check_idle(t, "reset");
        end
        rst_n = 1'b1;
    endtask

    task automatic load_program(int t);
        for (int i = 0; i < prog_len[t]; i++) begin
            load_valid = 1'b1;
            load.idx   = 8'(i);
            load.data  = prog[t][i];
            @(negedge clk);
            check_idle(t, "load");
        end
        load_valid = 1'b0;
    endtask

    task automatic start_core(int t);
        int waited;
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        waited = 0;
        while (running !== 1'b1 && waited < START_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (running !== 1'b1) begin
            $display("%0s: core did not start running after the start strobe", test_name[t]);
            errors++;
        end
    endtask

    task automatic collect_writes(int t);
        int waited;
        for (int k = 0; k < exp_len[t]; k++) begin
            waited = 0;
            @(negedge clk);
            while (host_wr_valid !== 1'b1 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (host_wr_valid !== 1'b1) begin
                $display("%0s: timed out waiting for host write %0d of %0d",
                         test_name[t], k, exp_len[t]);
                errors++;
                return;
            end
            if (host_wr.addr !== exp_wr[t][k].addr) begin
                $display("ERR %0s write %0d: host_wr.addr = %h, expected %h",
                         test_name[t], k, host_wr.addr, exp_wr[t][k].addr);
                errors++;
            end
            if (host_wr.data !== exp_wr[t][k].data) begin
                $display("ERR %0s write %0d: host_wr.data = %h, expected %h",
                         test_name[t], k, host_wr.data, exp_wr[t][k].data);
                errors++;
            end
        end
        // the halt loop must not reach the host
        repeat (QUIET_TIME) begin
            @(negedge clk);
            if (host_wr_valid !== 1'b0) begin
                $display("%0s: unexpected extra host write to %h after the last one",
                         test_name[t], host_wr.addr);
                errors++;
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        load_valid   = 1'b0;
        load         = '0;
        start        = 1'b0;
        errors       = 0;
        total_errors = 0;
        passed       = 0;
        failed       = 0;
        void'($urandom(32'ha070ebf9));
        build_programs();

        for (int t = 0; t < N_TESTS; t++) begin
            errors = 0;
            apply_reset(t);
            load_program(t);
            start_core(t);
            collect_writes(t);
            if (errors == 0) begin
                passed++;
                $display("test %0d %0s: ok, %0d host writes", t, test_name[t], exp_len[t]);
            end else begin
                failed++;
                $display("test %0d %0s: %0d errors", t, test_name[t], errors);
            end
            total_errors += errors;
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 N_TESTS, passed, failed, total_errors);
        if (failed == 0 && total_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter realtime HALF_PERIOD = 5ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;   // 10 ns period
    end

endmodule
